// ==== Bender.yml ====
package:
  name: gem_csc_match

sources:
  - logic/gem_csc_pkg.sv
  - logic/gem_match_cfg.sv
  - logic/gem_csc_lut.sv
  - logic/cluster_to_cscwirehalfstrip.sv
  - logic/gem_csc_match_top.sv
  - target: test
    files:
      - sim/gem_csc_match_chk.sv
      - sim/gem_csc_match_tb.sv

// ==== compile.f ====
logic/gem_csc_pkg.sv
logic/gem_match_cfg.sv
logic/gem_csc_lut.sv
logic/cluster_to_cscwirehalfstrip.sv
logic/gem_csc_match_top.sv
sim/gem_csc_match_chk.sv
sim/gem_csc_match_tb.sv

// ==== logic/cluster_to_cscwirehalfstrip.sv ====
`timescale 1ns/100ps

module cluster_to_cscwirehalfstrip (
   input  logic                           logic_clock,
   input  logic                           rst_n,
   input  gem_csc_pkg::match_cfg_t        cfg,
   input  gem_csc_pkg::gem_cluster_t      cluster,
   output logic [1:0][7:0]                pad_adr,     // [0] low pad, [1] high pad
   output logic [2:0]                     roll_adr,
   output logic                           r_even,
   input  gem_csc_pkg::xky_pair_t [1:0]   pad_data,    // one cycle after pad_adr
   input  gem_csc_pkg::wg_pair_t          roll_data,
   output gem_csc_pkg::match_result_t     result
);

   import gem_csc_pkg::*;

   gem_cluster_t  cluster_q;                    // aligned with table read data
   match_cfg_t    cfg_q;                        // settings seen when the cluster came in
   logic          in_me1a;
   logic [6:0]    dxky;                         // key half-width in eighth strips
   logic [6:0]    dwire;
   csc_window_t   wire_fit;
   csc_window_t   me1b_fit;
   csc_window_t   me1a_fit;
   csc_window_t   none_win;
   match_result_t result_d;

   // lo/2 + hi/2, rounded up when either end is odd
   function automatic logic [xkybits-1:0] mid_point(
      input logic [xkybits-1:0] lo,
      input logic [xkybits-1:0] hi
   );
      return lo[xkybits-1:1] + hi[xkybits-1:1] + {{(xkybits-1){1'b0}}, lo[0] | hi[0]};
   endfunction

   // order the two table values, widen by d and clamp into [lim_lo, lim_hi]
   function automatic csc_window_t make_window(
      input logic [xkybits-1:0] a,
      input logic [xkybits-1:0] b,
      input logic [6:0]         d,
      input logic [xkybits-1:0] lim_lo,
      input logic [xkybits-1:0] lim_hi
   );
      logic [xkybits:0] lo;                     // one extra bit so hi + d cannot wrap
      logic [xkybits:0] hi;
      logic [xkybits:0] sum;
      csc_window_t      w;
      lo = (a < b) ? a : b;                     // tables may hold lo and hi swapped
      hi = (a < b) ? b : a;
      sum = hi + d;
      w.lo = (lo > lim_lo + d) ? xkybits'(lo - d) : lim_lo;
      w.hi = (sum > lim_hi) ? lim_hi : xkybits'(sum);
      w.mi = mid_point(w.lo, w.hi);
      return w;
   endfunction

   // lookup addresses, invalid clusters park on pad 0
   assign pad_adr[0] = cluster.vpf ? cluster.pad : 8'd0;
   assign pad_adr[1] = cluster.vpf ? cluster.pad + {5'b0, cluster.size} : 8'd0;  // wraps at 256
   assign roll_adr   = cluster.roll;
   assign r_even     = cfg.evenchamber;         // bank follows chamber parity

   // stage 1: cluster and settings registered alongside the table reads
   always_ff @(posedge logic_clock) begin
      cluster_q <= cluster;
      cfg_q     <= cfg;
      if (!rst_n) begin
         cluster_q.vpf <= 1'b0;
         cfg_q         <= '0;
      end
   end

   assign in_me1a = (cluster_q.roll == me1a_roll);   // roll 7 only

   assign dxky  = {cfg_q.deltahs, 2'b00};      // half strip -> eighth strip
   assign dwire = {4'b0, cfg_q.deltawire};

   // wiregroup window from the roll table
   assign wire_fit = make_window(xkybits'(roll_data.lo), xkybits'(roll_data.hi),
                                 dwire, '0, xkybits'(max_wire));

   // key windows, both computed, one kept
   assign me1b_fit = make_window(pad_data[0].me1b, pad_data[1].me1b,
                                 dxky, min_xky_me1b, max_xky_me1b);
   assign me1a_fit = make_window(pad_data[0].me1a, pad_data[1].me1a,
                                 dxky, min_xky_me1a, max_xky_me1a);

   // marker for the region the cluster is not in
   assign none_win.lo = xky_none;
   assign none_win.hi = xky_none;
   assign none_win.mi = mid_point(xky_none, xky_none);

   always_comb begin
      result_d                 = '0;
      result_d.csc_cluster     = cluster_q;
      result_d.csc_cluster.vpf = cluster_q.vpf & cfg_q.match_enable;
      result_d.me1a            = in_me1a;
      result_d.wire_win        = wire_fit;
      result_d.me1b_win        = in_me1a ? none_win : me1b_fit;
      result_d.me1a_win        = in_me1a ? me1a_fit : none_win;
   end

   // stage 2: output register
   always_ff @(posedge logic_clock) begin
      result <= result_d;
      if (!rst_n) begin
         result.csc_cluster.vpf <= 1'b0;        // nothing valid out of reset
      end
   end

endmodule

// ==== logic/gem_csc_lut.sv ====
`timescale 1ns/100ps

module gem_csc_lut #(
   parameter type entry_t    = logic [15:0],
   parameter int  depth      = 8,
   parameter int  read_ports = 1
) (
   input  logic                                      logic_clock,
   input  logic                                      we,
   input  logic                                      w_even,   // 1 = even-chamber bank
   input  logic [$clog2(depth)-1:0]                  w_adr,
   input  entry_t                                    w_data,
   input  logic                                      r_even,
   input  logic [read_ports-1:0][$clog2(depth)-1:0]  r_adr,
   output entry_t [read_ports-1:0]                   r_data
);

   entry_t bank_even [depth];
   entry_t bank_odd  [depth];

   // maps start empty, filled over the register bus
   initial begin
      for (int i = 0; i < depth; i++) begin
         bank_even[i] = '0;
         bank_odd[i]  = '0;
      end
   end

   // single write port shared by both banks
   always_ff @(posedge logic_clock) begin
      if (we && (w_adr < depth)) begin         // addresses past the end are dropped
         if (w_even) begin
            bank_even[w_adr] <= w_data;
         end else begin
            bank_odd[w_adr] <= w_data;
         end
      end
   end

   // registered reads, one per port, all from the same bank
   always_ff @(posedge logic_clock) begin
      for (int p = 0; p < read_ports; p++) begin
         if (r_adr[p] >= depth) begin
            r_data[p] <= '0;                    // unmapped pad
         end else if (r_even) begin
            r_data[p] <= bank_even[r_adr[p]];
         end else begin
            r_data[p] <= bank_odd[r_adr[p]];
         end
      end
   end

endmodule

// ==== logic/gem_csc_match_top.sv ====
`timescale 1ns/100ps

module gem_csc_match_top (
   input  logic                        logic_clock,
   input  logic                        rst_n,
   input  logic                        cfg_we,
   input  gem_csc_pkg::cfg_addr_t      cfg_addr,
   input  gem_csc_pkg::cfg_data_t      cfg_wdata,
   input  gem_csc_pkg::gem_cluster_t   cluster,   // sampled every cycle
   output gem_csc_pkg::match_result_t  result     // two cycles after cluster
);

   import gem_csc_pkg::*;

   match_cfg_t            cfg;
   logic                  pad_we;
   logic                  roll_we;
   logic                  tbl_even;
   logic [7:0]            tbl_adr;
   xky_pair_t             pad_wdata;
   wg_pair_t              roll_wdata;
   logic [1:0][7:0]       pad_adr;
   logic [2:0]            roll_adr;
   logic                  r_even;
   xky_pair_t [1:0]       pad_data;
   wg_pair_t              roll_data;

   // settings and table write decode
   gem_match_cfg ucfg (
      .logic_clock (logic_clock),
      .rst_n       (rst_n),
      .cfg_we      (cfg_we),
      .cfg_addr    (cfg_addr),
      .cfg_wdata   (cfg_wdata),
      .cfg         (cfg),
      .pad_we      (pad_we),
      .roll_we     (roll_we),
      .tbl_even    (tbl_even),
      .tbl_adr     (tbl_adr),
      .pad_wdata   (pad_wdata),
      .roll_wdata  (roll_wdata)
   );

   // pad -> me1a/me1b key, low and high pad read together
   gem_csc_lut #(
      .entry_t    (xky_pair_t),
      .depth      (pad_entries),
      .read_ports (2)
   ) upad_lut (
      .logic_clock (logic_clock),
      .we          (pad_we),
      .w_even      (tbl_even),
      .w_adr       (tbl_adr),
      .w_data      (pad_wdata),
      .r_even      (r_even),
      .r_adr       (pad_adr),
      .r_data      (pad_data)
   );

   // roll -> wiregroup range
   gem_csc_lut #(
      .entry_t    (wg_pair_t),
      .depth      (roll_entries),
      .read_ports (1)
   ) uroll_lut (
      .logic_clock (logic_clock),
      .we          (roll_we),
      .w_even      (tbl_even),
      .w_adr       (tbl_adr[2:0]),
      .w_data      (roll_wdata),
      .r_even      (r_even),
      .r_adr       (roll_adr),
      .r_data      (roll_data)
   );

   cluster_to_cscwirehalfstrip utranslate (
      .logic_clock (logic_clock),
      .rst_n       (rst_n),
      .cfg         (cfg),
      .cluster     (cluster),
      .pad_adr     (pad_adr),
      .roll_adr    (roll_adr),
      .r_even      (r_even),
      .pad_data    (pad_data),
      .roll_data   (roll_data),
      .result      (result)
   );

endmodule

// ==== logic/gem_csc_pkg.sv ====
package gem_csc_pkg;

   // csc coordinate widths
   localparam int wirebits = 7;                  // wiregroup, 0-47
   localparam int xkybits  = 10;                 // eighth-strip key over 7 cfebs

   localparam logic [wirebits-1:0] max_wire = 7'd47;  // 48 wiregroups counted from 0

   // eighth-strip key limits per region
   localparam logic [xkybits-1:0] min_xky_me1b = 10'd0;
   localparam logic [xkybits-1:0] max_xky_me1b = 10'd511;
   localparam logic [xkybits-1:0] min_xky_me1a = 10'd512;
   localparam logic [xkybits-1:0] max_xky_me1a = 10'd895;
   localparam logic [xkybits-1:0] xky_none     = 10'd1023; // cluster not in this region

   localparam logic [2:0] me1a_roll = 3'd7;       // eta partition that overlaps me1a

   // lookup table depths
   localparam int pad_entries  = 192;           // gem pads per roll
   localparam int roll_entries = 8;

   // register bus
   // address bits 9:8 pick the space, bits 7:0 the pad entry or bits 2:0 the roll entry
   // table parity rides in the data word since bits 7:0 are all needed for pads
   typedef logic [9:0]  cfg_addr_t;
   typedef logic [31:0] cfg_data_t;

   localparam logic [1:0] space_ctrl = 2'd0;
   localparam logic [1:0] space_pad  = 2'd1;
   localparam logic [1:0] space_roll = 2'd2;

   localparam int tbl_even_bit = 31;            // 1 = write the even-chamber bank

   // control register fields
   localparam int ctrl_even_bit   = 0;
   localparam int ctrl_enable_bit = 1;
   localparam int ctrl_dhs_lsb    = 4;          // bits 8:4
   localparam int ctrl_dwire_lsb  = 12;         // bits 14:12

   // table entry fields on the data word
   localparam int pad_me1b_lsb = 0;             // bits 9:0
   localparam int pad_me1a_lsb = 16;            // bits 25:16
   localparam int roll_lo_lsb  = 0;             // bits 6:0
   localparam int roll_hi_lsb  = 8;             // bits 14:8

   typedef struct packed {
      logic [13:0] raw;                         // cluster word as received
      logic        vpf;                         // valid
      logic [2:0]  roll;                        // eta partition 0-7
      logic [7:0]  pad;                         // first pad 0-191
      logic [2:0]  size;                        // extra pads, 0 means one pad
   } gem_cluster_t;

   typedef struct packed {
      logic       evenchamber;
      logic       match_enable;
      logic [4:0] deltahs;                      // half-width in half strips
      logic [2:0] deltawire;                    // half-width in wiregroups
   } match_cfg_t;

   // pad table entry, one key per region
   typedef struct packed {
      logic [xkybits-1:0] me1a;
      logic [xkybits-1:0] me1b;
   } xky_pair_t;

   // roll table entry
   typedef struct packed {
      logic [wirebits-1:0] lo;
      logic [wirebits-1:0] hi;
   } wg_pair_t;

   typedef struct packed {
      logic [xkybits-1:0] lo;
      logic [xkybits-1:0] hi;
      logic [xkybits-1:0] mi;
   } csc_window_t;

   typedef struct packed {
      gem_cluster_t csc_cluster;                // vpf already gated by match_enable
      logic         me1a;                       // 1 when the cluster maps to me1a
      csc_window_t  wire_win;                   // upper bits zero
      csc_window_t  me1b_win;
      csc_window_t  me1a_win;
   } match_result_t;

endpackage

// ==== logic/gem_match_cfg.sv ====
`timescale 1ns/100ps

module gem_match_cfg (
   input  logic                     logic_clock,
   input  logic                     rst_n,
   input  logic                     cfg_we,       // one-cycle write strobe
   input  gem_csc_pkg::cfg_addr_t   cfg_addr,
   input  gem_csc_pkg::cfg_data_t   cfg_wdata,
   output gem_csc_pkg::match_cfg_t  cfg,
   output logic                     pad_we,
   output logic                     roll_we,
   output logic                     tbl_even,
   output logic [7:0]               tbl_adr,
   output gem_csc_pkg::xky_pair_t   pad_wdata,
   output gem_csc_pkg::wg_pair_t    roll_wdata
);

   import gem_csc_pkg::*;

   logic [1:0] space;                           // address space of the current access
   logic       ctrl_we;

   assign space   = cfg_addr[9:8];
   assign ctrl_we = cfg_we && (space == space_ctrl);

   // control register, visible to the translator one cycle after the write
   always_ff @(posedge logic_clock) begin
      if (!rst_n) begin
         cfg <= '0;                             // matching off, odd chamber
      end else if (ctrl_we) begin
         cfg.evenchamber  <= cfg_wdata[ctrl_even_bit];
         cfg.match_enable <= cfg_wdata[ctrl_enable_bit];
         cfg.deltahs      <= cfg_wdata[ctrl_dhs_lsb +: 5];
         cfg.deltawire    <= cfg_wdata[ctrl_dwire_lsb +: 3];
      end
   end

   // table writes pass straight through so they land on the same edge
   assign pad_we  = cfg_we && (space == space_pad);
   assign roll_we = cfg_we && (space == space_roll);

   assign tbl_even = cfg_wdata[tbl_even_bit];

   // pad entry address, the roll table takes the low three bits
   assign tbl_adr = cfg_addr[7:0];

   // unpack data word into entry structs
   assign pad_wdata.me1b = cfg_wdata[pad_me1b_lsb +: xkybits];
   assign pad_wdata.me1a = cfg_wdata[pad_me1a_lsb +: xkybits];

   assign roll_wdata.lo = cfg_wdata[roll_lo_lsb +: wirebits];
   assign roll_wdata.hi = cfg_wdata[roll_hi_lsb +: wirebits];

endmodule

// ==== sim/gem_csc_match_chk.sv ====
`timescale 1ns/100ps

module gem_csc_match_chk (
   input logic                        logic_clock,
   input logic                        rst_n,
   input gem_csc_pkg::match_result_t  result
);

   import gem_csc_pkg::*;

   int          assert_errors = 0;             // failed assertions so far
   csc_window_t other_win;                     // window of the region the cluster is not in

   assign other_win = result.me1a ? result.me1b_win : result.me1a_win;

   // pipeline comes out of reset empty
   reset_clears_vpf: assert property (@(posedge logic_clock)
      !rst_n |=> !result.csc_cluster.vpf)
      else begin
         assert_errors++;
         $error("result vpf set in the cycle after reset");
      end

   // wiregroup window ordered and inside the chamber
   wire_in_range: assert property (@(posedge logic_clock) disable iff (!rst_n)
      result.wire_win.lo <= result.wire_win.hi && result.wire_win.hi <= xkybits'(max_wire))
      else begin
         assert_errors++;
         $error("wire window out of order or past the last wiregroup");
      end

   // unused region carries the marker on lo, hi and mi
   other_region_marked: assert property (@(posedge logic_clock) disable iff (!rst_n)
      other_win.lo == xky_none && other_win.hi == xky_none && other_win.mi == xky_none)
      else begin
         assert_errors++;
         $error("non-region window does not hold the marker value");
      end

endmodule

// ==== sim/gem_csc_match_tb.sv ====
`timescale 1ns/100ps

module gem_csc_match_tb;

   import gem_csc_pkg::*;

   // cycles per test, each call of apply_cycle is one cycle
   localparam int n_reset = 3;
   localparam int n_t1    = 41;                 // 20 + enable + 20
   localparam int n_fill  = 2 * (pad_entries + roll_entries);
   localparam int n_t2    = 4 * 31;             // 4 bursts of control + 30
   localparam int n_t3    = 2 * 41;
   localparam int n_t4    = 32 + 2 * 21;        // swapped entries, then two bursts
   localparam int n_t5    = 61;
   localparam int n_flush = 2;
   localparam int cycle_limit = n_reset + n_t1 + n_fill + n_t2 + n_t3 + n_t4 + n_t5
                                + n_flush + 100;

   logic          logic_clock;
   logic          rst_n;
   logic          cfg_we;
   cfg_addr_t     cfg_addr;
   cfg_data_t     cfg_wdata;
   gem_cluster_t  cluster;
   match_result_t result;

   integer        seed = 32'h1146;
   int            cycle_cnt = 0;

   // reference copies of the four banks and the control register
   xky_pair_t     pad_even [pad_entries];
   xky_pair_t     pad_odd  [pad_entries];
   wg_pair_t      roll_even [roll_entries];
   wg_pair_t      roll_odd  [roll_entries];
   match_cfg_t    model_cfg;

   match_result_t exp_q [$];                    // two results in flight
   string         name_q [$];

   gem_csc_match_top UUT (
      .logic_clock (logic_clock),
      .rst_n       (rst_n),
      .cfg_we      (cfg_we),
      .cfg_addr    (cfg_addr),
      .cfg_wdata   (cfg_wdata),
      .cluster     (cluster),
      .result      (result)
   );

   bind cluster_to_cscwirehalfstrip gem_csc_match_chk uchk (
      .logic_clock (logic_clock),
      .rst_n       (rst_n),
      .result      (result)
   );

   always #20 logic_clock = ~logic_clock;      // 40 ns period

   always @(posedge logic_clock) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt > cycle_limit) begin
         $display("timeout: run did not finish within %0d cycles", cycle_limit);
         $display(">>> FAIL");
         $fatal(1, "simulation timed out");
      end
   end

   // a failed checker assertion ends the run at once
   always @(negedge logic_clock) begin
      if (UUT.utranslate.uchk.assert_errors != 0) begin
         $display("an assertion in the translator checker failed");
         $display(">>> FAIL");
         $fatal(1, "assertion failure");
      end
   end

   // halves summed, one more when either end is odd
   function automatic logic [xkybits-1:0] window_mid(input int lo, input int hi);
      return xkybits'(lo / 2 + hi / 2 + (((lo % 2) == 1 || (hi % 2) == 1) ? 1 : 0));
   endfunction

   function automatic csc_window_t fit_window(input int a, input int b, input int d,
                                              input int lim_lo, input int lim_hi);
      csc_window_t w;
      int          lo;
      int          hi;
      lo = (a > b) ? b : a;
      hi = (a > b) ? a : b;
      lo = (lo - d < lim_lo) ? lim_lo : lo - d;
      hi = (hi + d > lim_hi) ? lim_hi : hi + d;
      w.lo = xkybits'(lo);
      w.hi = xkybits'(hi);
      w.mi = window_mid(lo, hi);
      return w;
   endfunction

   function automatic xky_pair_t pad_entry(input logic even, input int adr);
      if (adr >= pad_entries) begin
         return '0;                             // unmapped pads read zero
      end
      return even ? pad_even[adr] : pad_odd[adr];
   endfunction

   // expected output for a cluster applied with the current model state
   function automatic match_result_t predict_result(input gem_cluster_t c);
      match_result_t r;
      xky_pair_t     k_lo;
      xky_pair_t     k_hi;
      wg_pair_t      wg;
      int            dhs;
      dhs  = int'(model_cfg.deltahs) * 4;      // half strips to eighth strips
      k_lo = pad_entry(model_cfg.evenchamber, c.vpf ? int'(c.pad) : 0);
      k_hi = pad_entry(model_cfg.evenchamber,
                       c.vpf ? (int'(c.pad) + int'(c.size)) % 256 : 0);
      wg   = model_cfg.evenchamber ? roll_even[c.roll] : roll_odd[c.roll];
      r = '0;
      r.csc_cluster     = c;
      r.csc_cluster.vpf = c.vpf & model_cfg.match_enable;
      r.me1a            = (c.roll == 3'd7);
      r.wire_win = fit_window(wg.lo, wg.hi, model_cfg.deltawire, 0, int'(max_wire));
      r.me1b_win = fit_window(k_lo.me1b, k_hi.me1b, dhs, 0, 511);
      r.me1a_win = fit_window(k_lo.me1a, k_hi.me1a, dhs, 512, 895);
      if (r.me1a) begin
         r.me1b_win = '{lo: xky_none, hi: xky_none, mi: window_mid(1023, 1023)};
      end else begin
         r.me1a_win = '{lo: xky_none, hi: xky_none, mi: window_mid(1023, 1023)};
      end
      return r;
   endfunction

   // bus write as seen by the reference banks
   task automatic update_model(input cfg_addr_t a, input cfg_data_t d);
      case (a[9:8])
         2'd0: begin
            model_cfg.evenchamber  = d[0];
            model_cfg.match_enable = d[1];
            model_cfg.deltahs      = d[8:4];
            model_cfg.deltawire    = d[14:12];
         end
         2'd1: begin
            if (a[7:0] < pad_entries && d[31]) pad_even[a[7:0]] = {d[25:16], d[9:0]};
            if (a[7:0] < pad_entries && !d[31]) pad_odd[a[7:0]] = {d[25:16], d[9:0]};
         end
         2'd2: begin
            if (d[31]) roll_even[a[2:0]] = {d[6:0], d[14:8]};
            else roll_odd[a[2:0]] = {d[6:0], d[14:8]};
         end
         default: ;                             // unused space
      endcase
   endtask

   task automatic check_window(input string name, input string field,
                               input csc_window_t exp, input csc_window_t act);
      if (exp !== act) begin
         $display("CHECK FAILED %s %s lo/hi/mi: expected %0d/%0d/%0d, actual %0d/%0d/%0d",
                  name, field, exp.lo, exp.hi, exp.mi, act.lo, act.hi, act.mi);
         $display(">>> FAIL");
         $fatal(1, "window mismatch");
      end
   endtask

   task automatic check_cluster(input string name, input gem_cluster_t exp,
                                input gem_cluster_t act);
      if (exp !== act) begin
         $display("CHECK FAILED %s cluster: expected %h, actual %h", name, exp, act);
         $display(">>> FAIL");
         $fatal(1, "cluster mismatch");
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (exp !== act) begin
         $display("CHECK FAILED %s me1a flag: expected %b, actual %b", name, exp, act);
         $display(">>> FAIL");
         $fatal(1, "me1a flag mismatch");
      end
   endtask

   task automatic check_oldest();
      match_result_t e;
      string         name;
      e    = exp_q.pop_front();
      name = name_q.pop_front();
      check_cluster(name, e.csc_cluster, result.csc_cluster);
      check_flag(name, e.me1a, result.me1a);
      check_window(name, "wire", e.wire_win, result.wire_win);
      check_window(name, "me1b", e.me1b_win, result.me1b_win);
      check_window(name, "me1a", e.me1a_win, result.me1a_win);
   endtask

   // one falling edge: check the result from two edges back, then drive
   task automatic apply_cycle(input gem_cluster_t c, input logic we, input cfg_addr_t a,
                              input cfg_data_t d, input string name);
      @(negedge logic_clock);
      if (exp_q.size() == 2) check_oldest();
      exp_q.push_back(predict_result(c));      // state before this cycle's write
      name_q.push_back(name);
      cluster   = c;
      cfg_we    = we;
      cfg_addr  = a;
      cfg_wdata = d;
      if (we) update_model(a, d);
   endtask

   // pad_span 0 draws from the whole 8-bit range, unmapped pads included
   task automatic random_cluster(input int pad_span, input bit favor_me1a,
                                 output gem_cluster_t c);
      logic [31:0] r;
      r = $random(seed);
      c.raw  = r[13:0];
      c.vpf  = (r[15:14] != 2'b00);             // about three in four valid
      c.size = r[18:16];
      c.roll = (favor_me1a && r[22]) ? 3'd7 : r[21:19];
      r = $random(seed);
      c.pad  = (pad_span == 0) ? r[7:0] : 8'(r[31:8] % pad_span);
   endtask

   task automatic send_clusters(input int n, input int pad_span, input bit favor_me1a,
                                input string name);
      gem_cluster_t c;
      for (int i = 0; i < n; i++) begin
         random_cluster(pad_span, favor_me1a, c);
         apply_cycle(c, 1'b0, '0, '0, name);
      end
   endtask

   task automatic set_control(input logic even, input logic en, input logic [4:0] dhs,
                              input logic [2:0] dw, input string name);
      cfg_data_t    d;
      gem_cluster_t c;
      d = '0;
      d[0]     = even;
      d[1]     = en;
      d[8:4]   = dhs;
      d[14:12] = dw;
      random_cluster(pad_entries, 1'b0, c);
      apply_cycle(c, 1'b1, 10'h000, d, name);
   endtask

   task automatic load_pad(input logic even, input logic [7:0] adr, input logic [9:0] me1b,
                           input logic [9:0] me1a, input string name);
      cfg_data_t    d;
      gem_cluster_t c;
      d = '0;
      d[31]    = even;                          // bank select rides on data bit 31
      d[9:0]   = me1b;
      d[25:16] = me1a;
      random_cluster(pad_entries, 1'b0, c);
      apply_cycle(c, 1'b1, {2'b01, adr}, d, name);
   endtask

   task automatic load_roll(input logic even, input logic [2:0] adr, input logic [6:0] lo,
                            input logic [6:0] hi, input string name);
      cfg_data_t    d;
      gem_cluster_t c;
      d = '0;
      d[31]   = even;
      d[6:0]  = lo;
      d[14:8] = hi;
      random_cluster(pad_entries, 1'b0, c);
      apply_cycle(c, 1'b1, {2'b10, 5'b0, adr}, d, name);
   endtask

   // realistic keys per region, wiregroups inside the chamber
   task automatic fill_tables();
      logic [31:0] r;
      for (int par = 1; par >= 0; par--) begin
         for (int p = 0; p < pad_entries; p++) begin
            r = $random(seed);
            load_pad(par[0], 8'(p), 10'(r[8:0]), 10'(512 + r[24:16] % 384), "table_load");
         end
         for (int w = 0; w < roll_entries; w++) begin
            r = $random(seed);
            load_roll(par[0], 3'(w), 7'(r[7:0] % 48), 7'(r[23:16] % 48), "table_load");
         end
      end
   endtask

   // lo above hi in both tables, keys fall with pad number
   task automatic load_swapped();
      logic [31:0] r;
      for (int par = 1; par >= 0; par--) begin
         for (int p = 0; p < 8; p++) begin
            load_pad(par[0], 8'(p), 10'(511 - 8 * p), 10'(895 - 8 * p), "swapped_entries");
         end
         for (int w = 0; w < roll_entries; w++) begin
            r = $random(seed);
            load_roll(par[0], 3'(w), 7'(40 + r[7:0] % 8), 7'(r[15:8] % 6), "swapped_entries");
         end
      end
   endtask

   task automatic flush_pipeline();
      repeat (2) begin
         @(negedge logic_clock);
         cfg_we = 1'b0;
         if (exp_q.size() > 0) check_oldest();
      end
   endtask

   initial begin
      logic_clock = 1'b0;
      rst_n       = 1'b0;
      cfg_we      = 1'b0;
      cfg_addr    = '0;
      cfg_wdata   = '0;
      cluster     = '0;
      model_cfg   = '0;                         // control register after reset
      for (int i = 0; i < pad_entries; i++) begin
         pad_even[i] = '0;
         pad_odd[i]  = '0;
      end
      for (int i = 0; i < roll_entries; i++) begin
         roll_even[i] = '0;
         roll_odd[i]  = '0;
      end
      repeat (2) @(posedge logic_clock);
      @(negedge logic_clock);
      rst_n = 1'b1;

      // matching off until enabled, then vpf passes through
      send_clusters(20, pad_entries, 1'b0, "reset_enable");
      set_control(1'b0, 1'b1, 5'd3, 3'd2, "reset_enable");
      send_clusters(20, pad_entries, 1'b0, "reset_enable");

      fill_tables();

      // parity flips between bursts
      for (int b = 0; b < 4; b++) begin
         set_control(b[0], 1'b1, 5'($random(seed)), 3'($random(seed)), "parity_bursts");
         send_clusters(30, pad_entries, 1'b0, "parity_bursts");
      end

      // widest key window pushes into both region limits
      set_control(1'b1, 1'b1, 5'd31, 3'($random(seed)), "region_clamp");
      send_clusters(40, pad_entries, 1'b1, "region_clamp");
      set_control(1'b0, 1'b1, 5'd31, 3'($random(seed)), "region_clamp");
      send_clusters(40, pad_entries, 1'b1, "region_clamp");

      load_swapped();
      set_control(1'b1, 1'b1, 5'($random(seed)), 3'd7, "swapped_entries");
      send_clusters(20, 8, 1'b0, "swapped_entries");
      set_control(1'b0, 1'b1, 5'($random(seed)), 3'd7, "swapped_entries");
      send_clusters(20, 8, 1'b0, "swapped_entries");

      // valid and invalid back to back, unmapped pads too
      set_control(1'($random(seed)), 1'b1, 5'($random(seed)), 3'($random(seed)),
                  "mixed_valid");
      send_clusters(60, 0, 1'b0, "mixed_valid");

      flush_pipeline();
      if (UUT.utranslate.uchk.assert_errors == 0) begin
         $display(">>> PASS");
         $finish;
      end else begin
         $display("%0d assertion failures in the translator checker",
                  UUT.utranslate.uchk.assert_errors);
         $display(">>> FAIL");
         $fatal(1, "assertion failures");
      end
   end

endmodule
